/* common/vga_pkg.sv */
package vga_pkg;

	// sram word address width.
	localparam int C_ADDR_W = 20;

	// width of the horizontal and vertical counters.
	localparam int C_CNT_W = 12;

	// 640x480 at 60 Hz, horizontal timing in pixel clocks.
	localparam int C_H_ACTIVE = 640;
	localparam int C_H_FRONT  = 16;
	localparam int C_H_SYNC   = 96;
	localparam int C_H_BACK   = 48;

	// vertical timing in lines.
	localparam int C_V_ACTIVE = 480;
	localparam int C_V_FRONT  = 10;
	localparam int C_V_SYNC   = 2;
	localparam int C_V_BACK   = 33;

	// width of one colour channel on the dac.
	localparam int C_DAC_W = 8;

	// one rgb565 frame buffer word.
	typedef struct packed {
		logic [4:0] r; // bits 15:11.
		logic [5:0] g; // bits 10:5.
		logic [4:0] b; // bits 4:0.
	} pixel_t;

endpackage

/* vga/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; #(
	parameter int H_ACTIVE = C_H_ACTIVE,
	parameter int H_FRONT  = C_H_FRONT,
	parameter int H_SYNC   = C_H_SYNC,
	parameter int H_BACK   = C_H_BACK,
	parameter int V_ACTIVE = C_V_ACTIVE,
	parameter int V_FRONT  = C_V_FRONT,
	parameter int V_SYNC   = C_V_SYNC,
	parameter int V_BACK   = C_V_BACK
) (
	input  logic               i_25M_clk,
	input  logic               i_rst,
	input  logic               i_en,
	output logic               o_running,
	output logic               o_active,
	output logic               o_hs,
	output logic               o_vs,
	output logic               o_frame_start,
	output logic [C_CNT_W-1:0] o_x,
	output logic [C_CNT_W-1:0] o_y
);

	localparam logic [C_CNT_W-1:0] H_ACT_END = C_CNT_W'(H_ACTIVE);
	localparam logic [C_CNT_W-1:0] H_HS_BEG  = C_CNT_W'(H_ACTIVE + H_FRONT);
	localparam logic [C_CNT_W-1:0] H_HS_END  = C_CNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [C_CNT_W-1:0] H_TOTAL   = C_CNT_W'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
	localparam logic [C_CNT_W-1:0] V_ACT_END = C_CNT_W'(V_ACTIVE);
	localparam logic [C_CNT_W-1:0] V_VS_BEG  = C_CNT_W'(V_ACTIVE + V_FRONT);
	localparam logic [C_CNT_W-1:0] V_VS_END  = C_CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam logic [C_CNT_W-1:0] V_TOTAL   = C_CNT_W'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

	typedef enum logic {
		S_IDLE,
		S_RENEW
	} state_t;

	state_t state_r, state_w;

	logic [C_CNT_W-1:0] h_cnt_r, h_cnt_w;
	logic [C_CNT_W-1:0] v_cnt_r, v_cnt_w;

	logic running;
	logic line_last;
	logic frame_last;

	assign running    = (state_r == S_RENEW);
	assign line_last  = (h_cnt_r == H_TOTAL - 1'b1);
	assign frame_last = line_last && (v_cnt_r == V_TOTAL - 1'b1);

	// idle only ever leaves at the frame boundary where the counters are parked at zero.
	always_comb begin
		state_w = state_r;
		case (state_r)
			S_IDLE: begin
				if (i_en) begin
					state_w = S_RENEW;
				end
			end
			S_RENEW: begin
				if (frame_last && !i_en) begin
					state_w = S_IDLE; // finish the frame first.
				end
			end
			default: begin
				state_w = S_IDLE;
			end
		endcase
	end

	always_comb begin
		h_cnt_w = h_cnt_r;
		v_cnt_w = v_cnt_r;
		if (running) begin
			if (line_last) begin
				h_cnt_w = '0;
				if (v_cnt_r == V_TOTAL - 1'b1) begin
					v_cnt_w = '0;
				end
				else begin
					v_cnt_w = v_cnt_r + 1'b1; // step on line wrap.
				end
			end
			else begin
				h_cnt_w = h_cnt_r + 1'b1;
			end
		end
		else begin
			h_cnt_w = '0;
			v_cnt_w = '0;
		end
	end

	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= S_IDLE;
			h_cnt_r <= '0;
			v_cnt_r <= '0;
		end
		else begin
			state_r <= state_w;
			h_cnt_r <= h_cnt_w;
			v_cnt_r <= v_cnt_w;
		end
	end

	assign o_running     = running;
	assign o_x           = h_cnt_r;
	assign o_y           = v_cnt_r;
	assign o_active      = running && (h_cnt_r < H_ACT_END) && (v_cnt_r < V_ACT_END);
	assign o_hs          = !(running && (h_cnt_r >= H_HS_BEG) && (h_cnt_r < H_HS_END));
	assign o_vs          = !(running && (v_cnt_r >= V_VS_BEG) && (v_cnt_r < V_VS_END));
	assign o_frame_start = running && (h_cnt_r == '0) && (v_cnt_r == '0);

	a_h_in_range: assert property (
		@(posedge i_25M_clk) disable iff (i_rst)
		h_cnt_r < H_TOTAL
	);

	// the origin is only reached from the last cycle of a frame or out of idle.
	a_frame_start_origin: assert property (
		@(posedge i_25M_clk) disable iff (i_rst)
		o_frame_start |-> (h_cnt_r == '0) && (v_cnt_r == '0) && $past(frame_last || !running)
	);

endmodule

/* vga/vga_pixel_fetch.sv */
`timescale 1ns/1ps

module vga_pixel_fetch import vga_pkg::*; #(
	parameter int H_ACTIVE = C_H_ACTIVE
) (
	input  logic                i_25M_clk,
	input  logic                i_rst,
	input  logic                i_active,
	input  logic                i_frame_start,
	input  logic [C_ADDR_W-1:0] i_frame_base,
	output logic [C_ADDR_W-1:0] o_sram_addr,
	output logic                o_sram_oe_n,
	output logic                o_valid
);

	// words per frame buffer line.
	localparam logic [C_ADDR_W-1:0] STRIDE = C_ADDR_W'(H_ACTIVE);

	logic [C_ADDR_W-1:0] base_r;
	logic [C_ADDR_W-1:0] addr_cnt_r, addr_cnt_w;
	logic [C_ADDR_W-1:0] addr_cur;
	logic [C_CNT_W-1:0]  row_r;
	logic                row_done;

	// pixel (0,0) reads straight from the new base, the counter catches up behind it.
	assign addr_cur = i_frame_start ? i_frame_base : addr_cnt_r;

	always_comb begin
		addr_cnt_w = addr_cnt_r;
		if (i_active) begin
			addr_cnt_w = addr_cur + 1'b1; // blanking burns no addresses.
		end
	end

	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			base_r     <= '0;
			addr_cnt_r <= '0;
		end
		else begin
			if (i_frame_start) begin
				base_r <= i_frame_base; // held for the whole frame.
			end
			addr_cnt_r <= addr_cnt_w;
		end
	end

	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			o_sram_addr <= '0;
			o_sram_oe_n <= 1'b1;
			o_valid     <= 1'b0;
		end
		else begin
			if (i_active) begin
				o_sram_addr <= addr_cur;
			end
			o_sram_oe_n <= !i_active;
			o_valid     <= i_active;
		end
	end

	// last word of a line has just gone out.
	assign row_done = o_valid && !i_active;

	// active rows completed in this frame.
	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			row_r <= '0;
		end
		else if (i_frame_start) begin
			row_r <= '0;
		end
		else if (row_done) begin
			row_r <= row_r + 1'b1;
		end
	end

	a_addr_bound: assert property (
		@(posedge i_25M_clk) disable iff (i_rst)
		o_valid |-> (o_sram_addr - base_r) < STRIDE * (C_ADDR_W'(row_r) + 1'b1)
	);

endmodule

/* logic/vga_color_out.sv */
`timescale 1ns/1ps

module vga_color_out import vga_pkg::*; (
	input  logic               i_25M_clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  logic               i_hs,
	input  logic               i_vs,
	input  pixel_t             i_sram_data,
	output logic [C_DAC_W-1:0] o_r,
	output logic [C_DAC_W-1:0] o_g,
	output logic [C_DAC_W-1:0] o_b,
	output logic               o_hs,
	output logic               o_vs,
	output logic               o_blank_n
);

	logic               hs_d1;
	logic               vs_d1;
	logic [C_DAC_W-1:0] r_exp;
	logic [C_DAC_W-1:0] g_exp;
	logic [C_DAC_W-1:0] b_exp;

	// replicate the top bits so full scale maps to 8'hff.
	assign r_exp = {i_sram_data.r, i_sram_data.r[4:2]};
	assign g_exp = {i_sram_data.g, i_sram_data.g[5:4]};
	assign b_exp = {i_sram_data.b, i_sram_data.b[4:2]};

	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			o_r       <= '0;
			o_g       <= '0;
			o_b       <= '0;
			o_blank_n <= 1'b0;
		end
		else begin
			o_blank_n <= i_valid;
			if (i_valid) begin
				o_r <= r_exp;
				o_g <= g_exp;
				o_b <= b_exp;
			end
			else begin
				o_r <= '0; // black in blanking.
				o_g <= '0;
				o_b <= '0;
			end
		end
	end

	// sync comes straight off the counters, so it needs two stages here.
	always_ff @(posedge i_25M_clk or posedge i_rst) begin
		if (i_rst) begin
			hs_d1 <= 1'b1;
			vs_d1 <= 1'b1;
			o_hs  <= 1'b1;
			o_vs  <= 1'b1;
		end
		else begin
			hs_d1 <= i_hs;
			vs_d1 <= i_vs;
			o_hs  <= hs_d1;
			o_vs  <= vs_d1;
		end
	end

	// colour stays dark through blanking and through both sync pulses.
	a_black_in_blank: assert property (
		@(posedge i_25M_clk) disable iff (i_rst)
		(!o_blank_n || !o_hs || !o_vs) |-> (o_r == '0) && (o_g == '0) && (o_b == '0)
	);

endmodule

/* logic/vga_display_top.sv */
`timescale 1ns/1ps

module vga_display_top import vga_pkg::*; #(
	parameter int H_ACTIVE = C_H_ACTIVE,
	parameter int H_FRONT  = C_H_FRONT,
	parameter int H_SYNC   = C_H_SYNC,
	parameter int H_BACK   = C_H_BACK,
	parameter int V_ACTIVE = C_V_ACTIVE,
	parameter int V_FRONT  = C_V_FRONT,
	parameter int V_SYNC   = C_V_SYNC,
	parameter int V_BACK   = C_V_BACK
) (
	input  logic                i_25M_clk,
	input  logic                i_rst,
	input  logic                i_en,
	input  logic [C_ADDR_W-1:0] i_frame_base,
	input  pixel_t              i_sram_data,
	output logic [C_ADDR_W-1:0] o_sram_addr,
	output logic                o_sram_oe_n,
	output logic [C_DAC_W-1:0]  o_vga_r,
	output logic [C_DAC_W-1:0]  o_vga_g,
	output logic [C_DAC_W-1:0]  o_vga_b,
	output logic                o_vga_hs,
	output logic                o_vga_vs,
	output logic                o_vga_blank_n,
	output logic                o_vga_clk
);

	logic t_active;
	logic t_hs;
	logic t_vs;
	logic t_frame_start;
	logic f_valid;

	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) vga_timing_i (
		.i_25M_clk     (i_25M_clk),
		.i_rst         (i_rst),
		.i_en          (i_en),
		.o_running     (),
		.o_active      (t_active),
		.o_hs          (t_hs),
		.o_vs          (t_vs),
		.o_frame_start (t_frame_start),
		.o_x           (),
		.o_y           ()
	);

	vga_pixel_fetch #(
		.H_ACTIVE (H_ACTIVE)
	) vga_pixel_fetch_i (
		.i_25M_clk     (i_25M_clk),
		.i_rst         (i_rst),
		.i_active      (t_active),
		.i_frame_start (t_frame_start),
		.i_frame_base  (i_frame_base),
		.o_sram_addr   (o_sram_addr),
		.o_sram_oe_n   (o_sram_oe_n),
		.o_valid       (f_valid)
	);

	vga_color_out vga_color_out_i (
		.i_25M_clk   (i_25M_clk),
		.i_rst       (i_rst),
		.i_valid     (f_valid),
		.i_hs        (t_hs),
		.i_vs        (t_vs),
		.i_sram_data (i_sram_data),
		.o_r         (o_vga_r),
		.o_g         (o_vga_g),
		.o_b         (o_vga_b),
		.o_hs        (o_vga_hs),
		.o_vs        (o_vga_vs),
		.o_blank_n   (o_vga_blank_n)
	);

	assign o_vga_clk = ~i_25M_clk; // dac samples mid pixel.

endmodule

/* dv/sram_model.sv */
`timescale 1ns/1ps

module sram_model import vga_pkg::*; #(
	parameter int SEED = 32
) (
	input  logic [C_ADDR_W-1:0] i_addr,
	input  logic                i_oe_n,
	output pixel_t              o_data
);

	localparam int DEPTH = 1 << C_ADDR_W;

	// the checker reads this array directly for its expected pixels.
	pixel_t mem [DEPTH];

	// preload the whole frame buffer with seeded random words.
	initial begin
		integer seed;
		seed = SEED;
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = 16'($random(seed));
		end
	end

	// asynchronous read, the bus reads as zero while the output is disabled.
	assign o_data = i_oe_n ? pixel_t'('0) : mem[i_addr];

endmodule

/* dv/tb_vga_display.sv */
`timescale 1ns/1ps

module tb_vga_display import vga_pkg::*; ();

	localparam int H_ACTIVE = 8;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 3;
	localparam int H_BACK   = 2;
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 1;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_BEG       = H_ACTIVE + H_FRONT;
	localparam int HS_END       = HS_BEG + H_SYNC;
	localparam int VS_BEG       = V_ACTIVE + V_FRONT;
	localparam int VS_END       = VS_BEG + V_SYNC;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int RUN_CYCLES   = 9 * FRAME_CYCLES;
	localparam int TIMEOUT_CYC  = 12 * FRAME_CYCLES + 20;

	typedef struct packed {
		logic                active;
		logic                hs;
		logic                vs;
		logic [C_ADDR_W-1:0] addr;
		logic [23:0]         rgb;
	} exp_t;

	logic                i_25M_clk;
	logic                i_rst;
	logic                i_en;
	logic [C_ADDR_W-1:0] i_frame_base;
	pixel_t              sram_data;
	logic [C_ADDR_W-1:0] sram_addr;
	logic                sram_oe_n;
	logic [7:0]          vga_r;
	logic [7:0]          vga_g;
	logic [7:0]          vga_b;
	logic                vga_hs;
	logic                vga_vs;
	logic                vga_blank_n;
	logic                vga_clk;

	integer              seed;
	int                  value_errors = 0;
	int                  other_errors = 0;
	int                  frames_started = 0;
	int                  idle_returns = 0;
	int                  pixels_checked = 0;

	// reference model state.
	logic                m_running;
	int                  m_x;
	int                  m_y;
	logic [C_ADDR_W-1:0] m_base;
	exp_t                pred_d1;
	exp_t                pred_d2;

	vga_display_top #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) vga_display_top_i (
		.i_25M_clk     (i_25M_clk),
		.i_rst         (i_rst),
		.i_en          (i_en),
		.i_frame_base  (i_frame_base),
		.i_sram_data   (sram_data),
		.o_sram_addr   (sram_addr),
		.o_sram_oe_n   (sram_oe_n),
		.o_vga_r       (vga_r),
		.o_vga_g       (vga_g),
		.o_vga_b       (vga_b),
		.o_vga_hs      (vga_hs),
		.o_vga_vs      (vga_vs),
		.o_vga_blank_n (vga_blank_n),
		.o_vga_clk     (vga_clk)
	);

	sram_model #(
		.SEED (32)
	) sram_model_i (
		.i_addr (sram_addr),
		.i_oe_n (sram_oe_n),
		.o_data (sram_data)
	);

	initial begin
		i_25M_clk = 1'b0;
		forever #20 i_25M_clk = ~i_25M_clk;
	end

	// each field is shifted up and refilled from its own top bits.
	function automatic logic [23:0] expand_rgb565(input pixel_t p);
		logic [7:0] r8;
		logic [7:0] g8;
		logic [7:0] b8;
		r8 = (8'(p.r) << 3) | (8'(p.r) >> 2);
		g8 = (8'(p.g) << 2) | (8'(p.g) >> 4);
		b8 = (8'(p.b) << 3) | (8'(p.b) >> 2);
		return {r8, g8, b8};
	endfunction

	function automatic exp_t predict(input logic running, input int x, input int y,
		input logic [C_ADDR_W-1:0] base);
		exp_t e;
		e.active = running && (x < H_ACTIVE) && (y < V_ACTIVE);
		e.hs     = !(running && (x >= HS_BEG) && (x < HS_END));
		e.vs     = !(running && (y >= VS_BEG) && (y < VS_END));
		e.addr   = base + C_ADDR_W'(y * H_ACTIVE + x);
		e.rgb    = e.active ? expand_rgb565(sram_model_i.mem[e.addr]) : 24'h0;
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// e1 is one cycle old for the sram side and e2 two cycles old for the dac side.
	task automatic compare_outputs(input exp_t e1, input exp_t e2);
		check_value("o_sram_oe_n", 32'(!e1.active), 32'(sram_oe_n));
		if (e1.active) begin
			check_value("o_sram_addr", 32'(e1.addr), 32'(sram_addr));
		end
		check_value("o_vga_hs", 32'(e2.hs), 32'(vga_hs));
		check_value("o_vga_vs", 32'(e2.vs), 32'(vga_vs));
		check_value("o_vga_blank_n", 32'(e2.active), 32'(vga_blank_n));
		check_value("o_vga_r", 32'(e2.rgb[23:16]), 32'(vga_r));
		check_value("o_vga_g", 32'(e2.rgb[15:8]), 32'(vga_g));
		check_value("o_vga_b", 32'(e2.rgb[7:0]), 32'(vga_b));
	endtask

	// the dac clock sits opposite the pixel clock in the middle of each phase.
	always @(i_25M_clk) begin
		#10;
		check_value("o_vga_clk", 32'(!i_25M_clk), 32'(vga_clk));
	end

	always @(posedge i_25M_clk) begin
		exp_t now_e;
		if (i_rst) begin
			m_running = 1'b0;
			m_x       = 0;
			m_y       = 0;
			m_base    = '0;
			pred_d1   = predict(1'b0, 0, 0, '0);
			pred_d2   = pred_d1;
		end
		else begin
			if (m_running && (m_x == 0) && (m_y == 0)) begin
				m_base = i_frame_base; // base only moves at the frame boundary.
				frames_started++;
			end
			now_e = predict(m_running, m_x, m_y, m_base);
			compare_outputs(pred_d1, pred_d2);
			if (pred_d2.active) begin
				pixels_checked++;
			end
			pred_d2 = pred_d1;
			pred_d1 = now_e;
			if (!m_running) begin
				m_running = i_en;
			end
			else begin
				if ((m_x == H_TOTAL - 1) && (m_y == V_TOTAL - 1) && !i_en) begin
					m_running = 1'b0; // frame done, back to idle.
					idle_returns++;
				end
				if (m_x == H_TOTAL - 1) begin
					m_x = 0;
					m_y = (m_y == V_TOTAL - 1) ? 0 : m_y + 1;
				end
				else begin
					m_x++;
				end
			end
		end
	end

	initial begin
		int cyc;
		int quiet;
		int mid_run_returns;
		seed            = 32;
		i_rst           = 1'b1;
		i_en            = 1'b0;
		i_frame_base    = '0;
		quiet           = 0;
		mid_run_returns = 0;
		repeat (4) @(negedge i_25M_clk);
		i_rst = 1'b0;
		i_en  = 1'b1;
		for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(negedge i_25M_clk);
			if (($random(seed) & 32'd63) == 32'd0) begin
				i_en = !i_en;
			end
			if (($random(seed) & 32'd31) == 32'd0) begin
				i_frame_base = C_ADDR_W'($random(seed)); // often lands mid frame.
			end
		end
		mid_run_returns = idle_returns;
		i_en = 1'b0;
		// idle once no hsync pulse shows for longer than a line.
		while (quiet < H_TOTAL + 2) begin
			@(negedge i_25M_clk);
			if (vga_hs && sram_oe_n && !vga_blank_n) begin
				quiet++;
			end
			else begin
				quiet = 0;
			end
		end
		assert (mid_run_returns >= 1) else begin
			other_errors++;
			$display("the random enable never ended a frame before the final stop");
		end
		$display("errors: %0d value mismatches, %0d other, %0d frames, %0d pixels checked",
			value_errors, other_errors, frames_started, pixels_checked);
		if (value_errors + other_errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge i_25M_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT never settled back to idle", cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

/* vlog.f */
common/vga_pkg.sv
vga/vga_timing.sv
vga/vga_pixel_fetch.sv
logic/vga_color_out.sv
logic/vga_display_top.sv
dv/sram_model.sv
dv/tb_vga_display.sv

/* run.sh */
#!/bin/sh
# build and run the vga scan-out testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_vga_display -o sim_vga \
	&& ./obj_dir/sim_vga > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
